// File: build.f
+incdir+bench
rtl/cga_pkg.sv
rtl/bus_converter.sv
rtl/vram.sv
rtl/crtc_regs.sv
rtl/raster_scanner.sv
rtl/cga_card.sv
bench/cga_card_tb.sv

// File: Makefile
# Verilator build and run of the CGA card testbench

VERILATOR ?= verilator
TOP       ?= cga_card_tb
RTL_TOP   ?= cga_card
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Regression passed$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/cga_card_model.svh
// Reference model; needs AW and H_ACTIVE declared in the including module before the include
`ifndef CGA_CARD_MODEL_SVH
`define CGA_CARD_MODEL_SVH

// RAM byte for a host word, high byte one above the low byte
function automatic int byte_addr(input int word, input int hi);
    return (2 * word + hi) % (1 << AW);
endfunction

// Byte fetched for pixel (x,y), four pixels per byte, linear lines
function automatic int fetch_addr(input int start, input int x, input int y);
    return (start + y * (H_ACTIVE / 4) + x / 4) % (1 << AW);
endfunction

// Colour index for one pixel
function automatic logic [3:0] pixel_color(input logic [7:0] b, input int x, input logic en,
                                           input logic [3:0] bg, input logic pal,
                                           input logic inten);
    logic [1:0] v;
    logic [3:0] c;
    v = 2'((b >> (6 - 2 * (x % 4))) & 8'h03);  // Leftmost pixel in bits 7:6
    if (!en)
        c = 4'h0;
    else if (v == 2'd0)
        c = bg;
    else begin
        c = pal ? 4'(2 * v + 1) : 4'(2 * v);    // 2,4,6 or 3,5,7
        if (inten)
            c = c + 4'd8;
    end
    return c;
endfunction

// Register read-back, unselected bytes and unknown addresses give zero
function automatic logic [15:0] expected_reg(input logic [19:1] addr, input logic [1:0] sel,
                                             input logic [7:0] idx, input logic [7:0] shi,
                                             input logic [7:0] slo, input logic [7:0] mode,
                                             input logic [5:0] col);
    logic [15:0] w;
    w = 16'h0000;
    if (addr == 19'h001EA)                      // Ports 3D4/3D5
        w = {(idx == 8'h0C) ? shi : (idx == 8'h0D) ? slo : 8'h00, idx};
    else if (addr == 19'h001EC)                 // Ports 3D8/3D9
        w = {2'b00, col, mode};
    if (!sel[0])
        w[7:0] = 8'h00;                         // Low byte not selected
    if (!sel[1])
        w[15:8] = 8'h00;
    return w;
endfunction

`endif

// File: bench/cga_card_tb.sv
// Small raster timing for short frames; RAM content checked only at the 20 words the tests write
`default_nettype none

module cga_card_tb;

    import cga_pkg::*;

    localparam int AW = 14;
    localparam int H_ACTIVE = 16;
    localparam int H_FRONT = 2;
    localparam int H_SYNC = 2;
    localparam int H_BACK = 2;
    localparam int V_ACTIVE = 4;
    localparam int V_FRONT = 1;
    localparam int V_SYNC = 1;
    localparam int V_BACK = 1;
    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int TIMEOUT = 50;                // Cycles per bus access
    localparam int FRAME_TIMEOUT = 4 * H_TOTAL * V_TOTAL;
    localparam int NEVER = 1 << 30;

    `include "cga_card_model.svh"

    logic        clock;
    logic        rst_n;
    logic        regaccess;
    logic [19:1] data_addr;
    logic [15:0] data_wdata;
    logic [1:0]  data_bytesel;
    logic        data_we;
    logic [15:0] data_rdata;
    logic        data_ack;
    logic        memaccess;
    logic [14:1] mem_addr;
    logic [15:0] mem_wdata;
    logic [1:0]  mem_bytesel;
    logic        mem_we;
    logic [15:0] mem_rdata;
    logic        mem_ack;
    video_t      video;

    integer     seed = 54409;
    int         errors = 0;
    int         checks = 0;
    logic [7:0] shadow [0:2**AW-1];             // Mirror of every RAM write
    logic [7:0] crtc_idx = 8'h00;               // Register mirrors
    logic [7:0] start_hi = 8'h00;
    logic [7:0] start_lo = 8'h00;
    logic [7:0] mode_reg = 8'h00;
    logic [5:0] color_reg = 6'h00;
    int         frame_count;
    int         check_from = NEVER;             // First frame to compare
    int         pix_cnt;
    int         hs_rises;
    int         hs_cycles;
    int         vs_cycles;
    int         hb_cycles;
    int         vb_cycles;
    logic       prev_vs;
    logic       prev_hs;

    cga_card #(
        .AW(AW), .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) i_cga_card (
        .clock(clock), .rst_n(rst_n),
        .regaccess(regaccess), .data_addr(data_addr), .data_wdata(data_wdata),
        .data_bytesel(data_bytesel), .data_we(data_we), .data_rdata(data_rdata),
        .data_ack(data_ack),
        .memaccess(memaccess), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_bytesel(mem_bytesel), .mem_we(mem_we), .mem_rdata(mem_rdata), .mem_ack(mem_ack),
        .video(video)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, msg, actual,
                     expected);
        end
    endtask

    task automatic abort(input string msg);
        $display("Run stopped: %s", msg);
        $display("Regression failed");
        $finish;
    endtask

    // Word 0..15 at the bottom, 16..19 at the top of the RAM
    function automatic int pick_word(input int i);
        return (i < 16) ? i : (1 << (AW - 1)) - 20 + i;
    endfunction

    task automatic mem_access(input int word, input logic [15:0] wd, input logic [1:0] sel,
                              input logic we, output logic [15:0] rd);
        int n;
        @(posedge clock);
        memaccess   <= 1'b1;
        mem_addr    <= 14'(word);
        mem_wdata   <= wd;
        mem_bytesel <= sel;
        mem_we      <= we;
        n = 0;
        do begin
            @(negedge clock);
            n++;
            if (n > TIMEOUT)
                abort("memory access never got mem_ack");
        end while (!mem_ack);
        rd = mem_rdata;                         // Valid in the ack cycle
        @(posedge clock);
        memaccess <= 1'b0;
        @(negedge clock);
        check(32'(mem_rdata), 32'h0, "mem_rdata not zero while idle");
    endtask

    task automatic mem_write(input int word, input logic [15:0] wd, input logic [1:0] sel);
        logic [15:0] rd;
        mem_access(word, wd, sel, 1'b1, rd);
        if (sel[0])
            shadow[byte_addr(word, 0)] = wd[7:0];
        if (sel[1])
            shadow[byte_addr(word, 1)] = wd[15:8];
    endtask

    task automatic mem_read_check(input int word, input logic [1:0] sel);
        logic [15:0] rd;
        logic [15:0] exp;
        exp = {sel[1] ? shadow[byte_addr(word, 1)] : 8'h00,
               sel[0] ? shadow[byte_addr(word, 0)] : 8'h00};
        mem_access(word, 16'h0000, sel, 1'b0, rd);
        check(32'(rd), 32'(exp), $sformatf("memory read word %0h sel %0b", word, sel));
    endtask

    task automatic reg_access(input logic [19:1] addr, input logic [15:0] wd,
                              input logic [1:0] sel, input logic we, output logic [15:0] rd);
        int n;
        @(posedge clock);
        regaccess    <= 1'b1;
        data_addr    <= addr;
        data_wdata   <= wd;
        data_bytesel <= sel;
        data_we      <= we;
        n = 0;
        do begin
            @(negedge clock);
            n++;
            if (n > TIMEOUT)
                abort("register access never got data_ack");
        end while (!data_ack);
        check(32'(n), 32'd2, "data_ack not one cycle after access start");
        rd = data_rdata;
        @(posedge clock);
        regaccess <= 1'b0;
    endtask

    task automatic reg_write(input logic [19:1] addr, input logic [15:0] wd,
                             input logic [1:0] sel);
        logic [15:0] rd;
        logic [7:0]  old_idx;
        reg_access(addr, wd, sel, 1'b1, rd);
        old_idx = crtc_idx;                     // Data goes by the index held before
        if (addr == CRTC_WORD_ADDR) begin
            if (sel[0])
                crtc_idx = wd[7:0];
            if (sel[1] && old_idx == 8'h0C)
                start_hi = wd[15:8];
            if (sel[1] && old_idx == 8'h0D)
                start_lo = wd[15:8];
        end else if (addr == MODE_WORD_ADDR) begin
            if (sel[0])
                mode_reg = wd[7:0];
            if (sel[1])
                color_reg = wd[13:8];
        end
    endtask

    task automatic reg_read_check(input logic [19:1] addr, input logic [1:0] sel);
        logic [15:0] rd;
        reg_access(addr, 16'h0000, sel, 1'b0, rd);
        check(32'(rd), 32'(expected_reg(addr, sel, crtc_idx, start_hi, start_lo, mode_reg,
              color_reg)), $sformatf("register read %0h sel %0b", addr, sel));
    endtask

    task automatic set_start(input logic [15:0] s);
        reg_write(CRTC_WORD_ADDR, {8'h00, CRTC_START_HI}, 2'b01);
        reg_write(CRTC_WORD_ADDR, {s[15:8], 8'h00}, 2'b10);
        reg_write(CRTC_WORD_ADDR, {8'h00, CRTC_START_LO}, 2'b01);
        reg_write(CRTC_WORD_ADDR, {s[7:0], 8'h00}, 2'b10);
    endtask

    task automatic fill_ram();
        for (int i = 0; i < 20; i++)
            mem_write(pick_word(i), 16'($random(seed)), 2'b11);
    endtask

    task automatic wait_frames(input int n);
        int target;
        int cnt;
        target = frame_count + n;
        cnt = 0;
        while (frame_count < target) begin
            @(negedge clock);
            cnt++;
            if (cnt > n * FRAME_TIMEOUT)
                abort("frame boundary never came");
        end
    endtask

    // Compare the next complete frame, then stop comparing
    task automatic run_frame_check();
        @(posedge clock);
        check_from = frame_count + 1;
        wait_frames(2);
        check_from = NEVER;
    endtask

    task automatic test_done(input int n, input string name);
        $display("Test %0d %s finished, %0d errors so far", n, name, errors);
    endtask

    // Frame compare, a frame runs from one vsync fall to the next
    always @(negedge clock) begin
        if (!rst_n) begin
            frame_count = 0;
            pix_cnt = 0;
            hs_rises = 0;
            hs_cycles = 0;
            vs_cycles = 0;
            hb_cycles = 0;
            vb_cycles = 0;
            prev_vs = 1'b0;
            prev_hs = 1'b0;
        end else begin
            if (prev_vs && !video.vsync) begin
                if (frame_count >= check_from) begin
                    check(32'(pix_cnt), 32'(H_ACTIVE * V_ACTIVE), "de pixels per frame");
                    check(32'(hs_rises), 32'(V_TOTAL), "hsync pulses per frame");
                    check(32'(hs_cycles), 32'(V_TOTAL * H_SYNC), "hsync cycles per frame");
                    check(32'(vs_cycles), 32'(V_SYNC * H_TOTAL), "vsync length");
                    check(32'(hb_cycles), 32'(V_TOTAL * (H_TOTAL - H_ACTIVE)), "hblank cycles");
                    check(32'(vb_cycles), 32'(H_TOTAL * (V_TOTAL - V_ACTIVE)), "vblank cycles");
                end
                frame_count++;
                pix_cnt = 0;
                hs_rises = 0;
                hs_cycles = 0;
                vs_cycles = 0;
                hb_cycles = 0;
                vb_cycles = 0;
            end
            if (video.hsync && !prev_hs)
                hs_rises++;
            if (video.hsync)
                hs_cycles++;
            if (video.vsync)
                vs_cycles++;
            if (video.hblank)
                hb_cycles++;
            if (video.vblank)
                vb_cycles++;
            if (video.de) begin
                if (frame_count >= check_from)
                    check(32'(video.color), 32'(pixel_color(
                        shadow[fetch_addr({start_hi, start_lo}, pix_cnt % H_ACTIVE,
                                          pix_cnt / H_ACTIVE)],
                        pix_cnt % H_ACTIVE, mode_reg[3], color_reg[3:0], color_reg[5],
                        color_reg[4])), $sformatf("pixel %0d colour", pix_cnt));
                pix_cnt++;
            end
            prev_vs = video.vsync;
            prev_hs = video.hsync;
        end
    end

    initial begin
        int n;
        int w;
        logic [1:0] sel;
        rst_n        = 1'b0;
        regaccess    = 1'b0;
        data_addr    = '0;
        data_wdata   = '0;
        data_bytesel = '0;
        data_we      = 1'b0;
        memaccess    = 1'b0;
        mem_addr     = '0;
        mem_wdata    = '0;
        mem_bytesel  = '0;
        mem_we       = 1'b0;
        repeat (10) @(posedge clock);
        rst_n <= 1'b1;

        // Quiet outputs until the first sync
        n = 0;
        do begin
            @(negedge clock);
            if (n < H_ACTIVE + H_FRONT) begin
                check(32'(video.hsync), 32'h0, "hsync early after reset");
                check(32'(video.vsync), 32'h0, "vsync early after reset");
            end
            check(32'(video.de), 32'h0, "de before first vsync");
            check(32'(video.color), 32'h0, "colour before first vsync");
            n++;
            if (n > FRAME_TIMEOUT)
                abort("first vsync never came");
        end while (!video.vsync);
        test_done(1, "reset outputs");

        fill_ram();
        repeat (40) begin
            w = pick_word({$random(seed)} % 20);
            sel = 2'($random(seed));
            if ($random(seed) & 1)
                mem_write(w, 16'($random(seed)), sel);
            else
                mem_read_check(w, sel);
        end
        for (int i = 0; i < 20; i++)
            mem_read_check(pick_word(i), 2'b11);
        test_done(2, "memory bus");

        reg_write(CRTC_WORD_ADDR, 16'h000C, 2'b01);
        reg_read_check(CRTC_WORD_ADDR, 2'b01);
        reg_write(CRTC_WORD_ADDR, 16'hA500, 2'b10);
        reg_read_check(CRTC_WORD_ADDR, 2'b11);
        reg_write(CRTC_WORD_ADDR, 16'h5A0D, 2'b11);     // Index and data in one access
        reg_write(CRTC_WORD_ADDR, 16'h3C00, 2'b10);
        reg_read_check(CRTC_WORD_ADDR, 2'b11);
        reg_write(CRTC_WORD_ADDR, 16'h7705, 2'b11);
        reg_write(CRTC_WORD_ADDR, 16'h9900, 2'b10);     // Index 05 unknown
        reg_read_check(CRTC_WORD_ADDR, 2'b10);
        reg_write(CRTC_WORD_ADDR, 16'h000C, 2'b01);
        reg_read_check(CRTC_WORD_ADDR, 2'b11);
        reg_write(MODE_WORD_ADDR, 16'hFF37, 2'b11);
        reg_read_check(MODE_WORD_ADDR, 2'b11);
        reg_read_check(MODE_WORD_ADDR, 2'b01);
        reg_read_check(MODE_WORD_ADDR, 2'b10);
        reg_read_check(MODE_WORD_ADDR, 2'b00);
        reg_write(19'h001E0, 16'hFFFF, 2'b11);          // No register there
        reg_read_check(19'h001E0, 2'b11);
        reg_read_check(MODE_WORD_ADDR, 2'b11);
        test_done(3, "register access");

        for (int i = 0; i < 16; i++)
            mem_write(i, 16'($random(seed)), 2'b11);
        set_start(16'h0000);
        reg_write(MODE_WORD_ADDR, {4'h0, 4'($random(seed)), 8'h08}, 2'b11);
        run_frame_check();
        test_done(4, "frame palette 0");

        fill_ram();
        set_start(16'hFFFA);                            // Wraps past the RAM top
        reg_write(MODE_WORD_ADDR, {4'h3, 4'($random(seed)), 8'h08}, 2'b11);
        run_frame_check();
        test_done(5, "frame palette 1 with wrap");

        reg_write(MODE_WORD_ADDR, 16'h0000, 2'b01);
        run_frame_check();
        test_done(6, "video disabled");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    initial begin
        #(20 * 400000);
        $display("Simulation ran too long and was stopped");
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/cga_card.sv
// Single clock, graphics mode only; host word addresses wrap into the 2^AW byte RAM
`default_nettype none

module cga_card #(
    parameter int AW       = 14,
    parameter int H_ACTIVE = 320,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 32,
    parameter int H_BACK   = 32,
    parameter int V_ACTIVE = 200,
    parameter int V_FRONT  = 20,
    parameter int V_SYNC   = 4,
    parameter int V_BACK   = 38
) (
    input  logic            clock,
    input  logic            rst_n,
    // I/O port
    input  logic            regaccess,
    input  logic [19:1]     data_addr,
    input  logic [15:0]     data_wdata,
    input  logic [1:0]      data_bytesel,
    input  logic            data_we,
    output logic [15:0]     data_rdata,
    output logic            data_ack,
    // Memory port
    input  logic            memaccess,
    input  logic [14:1]     mem_addr,
    input  logic [15:0]     mem_wdata,
    input  logic [1:0]      mem_bytesel,
    input  logic            mem_we,
    output logic [15:0]     mem_rdata,
    output logic            mem_ack,
    output cga_pkg::video_t video
);

    import cga_pkg::*;

    mem_req_t   mem_req;
    vram_port_t host_port;                      // Converter to RAM
    vram_port_t video_port;                     // Scanner to RAM
    logic [7:0] host_rdata;
    logic [7:0] video_rdata;
    crtc_cfg_t  cfg;

    assign mem_req = '{addr: mem_addr, wdata: mem_wdata, bytesel: mem_bytesel, we: mem_we};

    bus_converter #(.AW(AW)) i_bus_converter (
        .clock     (clock),
        .rst_n     (rst_n),
        .memaccess (memaccess),
        .req       (mem_req),
        .rdata     (mem_rdata),
        .ack       (mem_ack),
        .ram_req   (host_port),
        .ram_rdata (host_rdata)
    );

    vram #(.AW(AW)) i_vram (
        .clock   (clock),
        .a_port  (host_port),
        .a_rdata (host_rdata),
        .b_port  (video_port),
        .b_rdata (video_rdata)
    );

    crtc_regs i_crtc_regs (
        .clock     (clock),
        .rst_n     (rst_n),
        .regaccess (regaccess),
        .addr      (data_addr),
        .wdata     (data_wdata),
        .bytesel   (data_bytesel),
        .we        (data_we),
        .rdata     (data_rdata),
        .ack       (data_ack),
        .cfg       (cfg)
    );

    raster_scanner #(
        .AW       (AW),
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) i_raster_scanner (
        .clock     (clock),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .ram_req   (video_port),
        .ram_rdata (video_rdata),
        .video     (video)
    );

endmodule

`default_nettype wire

// File: rtl/raster_scanner.sv
// Every timing value must be at least 1 and H_ACTIVE a multiple of 4; de waits for the first vsync
`default_nettype none

module raster_scanner #(
    parameter int AW       = 14,
    parameter int H_ACTIVE = 320,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 32,
    parameter int H_BACK   = 32,
    parameter int V_ACTIVE = 200,
    parameter int V_FRONT  = 20,
    parameter int V_SYNC   = 4,
    parameter int V_BACK   = 38
) (
    input  logic                clock,
    input  logic                rst_n,
    input  cga_pkg::crtc_cfg_t  cfg,
    output cga_pkg::vram_port_t ram_req,
    input  logic [7:0]          ram_rdata,
    output cga_pkg::video_t     video
);

    import cga_pkg::*;

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int HW      = $clog2(H_TOTAL);
    localparam int VW      = $clog2(V_TOTAL);

    localparam logic [HW-1:0] H_END    = HW'(H_ACTIVE);
    localparam logic [HW-1:0] HS_BEGIN = HW'(H_ACTIVE + H_FRONT);
    localparam logic [HW-1:0] HS_END   = HW'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam logic [HW-1:0] H_LAST   = HW'(H_TOTAL - 1);
    localparam logic [VW-1:0] V_END    = VW'(V_ACTIVE);
    localparam logic [VW-1:0] VS_BEGIN = VW'(V_ACTIVE + V_FRONT);
    localparam logic [VW-1:0] VS_END   = VW'(V_ACTIVE + V_FRONT + V_SYNC);
    localparam logic [VW-1:0] V_LAST   = VW'(V_TOTAL - 1);
    localparam logic [AW-1:0] LINE_BYTES = AW'(H_ACTIVE / 4);   // Four pixels per byte

    logic [HW-1:0] hcnt;
    logic [VW-1:0] vcnt;
    logic [AW-1:0] line_base;                   // Offset of current line
    logic [AW-1:0] fetch_addr;
    logic          armed;                       // Set once the first vsync starts
    logic          line_end;
    logic          hblank;
    logic          vblank;
    logic          hsync;
    logic          vsync;
    logic          active;
    logic [4:0]    s1_timing;                   // hsync, vsync, hblank, vblank, de
    logic [1:0]    s1_phase;                    // x mod 4 of the returning byte
    logic [1:0]    pix;
    logic [3:0]    color;

    assign line_end = (hcnt == H_LAST);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            hcnt      <= '0;
            vcnt      <= '0;
            line_base <= '0;
            armed     <= 1'b0;
        end else begin
            hcnt <= line_end ? '0 : hcnt + 1'b1;
            if (line_end) begin
                if (vcnt == V_LAST) begin
                    vcnt      <= '0;
                    line_base <= '0;            // New frame
                end else begin
                    vcnt <= vcnt + 1'b1;
                    if (!vblank)
                        line_base <= line_base + LINE_BYTES;
                end
            end
            if (vsync)
                armed <= 1'b1;
        end
    end

    // Line order is active, front porch, sync, back porch
    assign hblank = (hcnt >= H_END);
    assign vblank = (vcnt >= V_END);
    assign hsync  = (hcnt >= HS_BEGIN) && (hcnt < HS_END);
    assign vsync  = (vcnt >= VS_BEGIN) && (vcnt < VS_END);
    assign active = !hblank && !vblank;

    // One fetch per active pixel, wraps at 2^AW
    assign fetch_addr = cfg.start_addr[AW-1:0] + line_base + AW'(hcnt >> 2);
    assign ram_req    = '{en: active, we: 1'b0, addr: 16'(fetch_addr), data: 8'h00};

    // Byte returns one cycle later, bits 7:6 hold the leftmost pixel
    assign pix = ram_rdata[{~s1_phase, 1'b0} +: 2];

    always_comb begin
        if (!s1_timing[0] || !cfg.video_en)
            color = 4'h0;                       // Blanked or video off
        else if (pix == 2'd0)
            color = cfg.bg_color;
        else if (cfg.pal_sel)
            color = PALETTE1[pix] + {cfg.intensity, 3'b000};
        else
            color = PALETTE0[pix] + {cfg.intensity, 3'b000};
    end

    // Two-stage pipeline keeps timing and colour aligned
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            s1_timing <= '0;
            s1_phase  <= '0;
            video     <= '0;
        end else begin
            s1_timing <= {hsync, vsync, hblank, vblank, active && armed};
            s1_phase  <= hcnt[1:0];
            video     <= {s1_timing, color};
        end
    end

    // Pixels only appear inside the visible area
    assert property (@(posedge clock) disable iff (!rst_n)
        video.de |-> (!video.hblank && !video.vblank))
        else $error("raster_scanner: de during blanking");

endmodule

`default_nettype wire

// File: rtl/crtc_regs.sv
// Only CRTC indices 0C/0D exist; a data write uses the index stored before the access
`default_nettype none

module crtc_regs (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               regaccess,
    input  logic [19:1]        addr,
    input  logic [15:0]        wdata,
    input  logic [1:0]         bytesel,
    input  logic               we,
    output logic [15:0]        rdata,
    output logic               ack,
    output cga_pkg::crtc_cfg_t cfg
);

    import cga_pkg::*;

    logic [7:0]  crtc_index;
    logic [7:0]  start_hi;
    logic [7:0]  start_lo;
    logic [7:0]  mode_reg;                      // Bit 3 video enable
    logic [5:0]  color_reg;                     // Bg 3:0, intensity 4, palette 5
    logic        new_access;
    logic        crtc_hit;
    logic        mode_hit;
    logic [7:0]  crtc_data;
    logic [15:0] rd_word;

    assign new_access = regaccess && !ack;      // First cycle only
    assign crtc_hit   = (addr == CRTC_WORD_ADDR);
    assign mode_hit   = (addr == MODE_WORD_ADDR);

    // Indexed register read
    always_comb begin
        case (crtc_index)
            CRTC_START_HI: crtc_data = start_hi;
            CRTC_START_LO: crtc_data = start_lo;
            default:       crtc_data = 8'h00;
        endcase
    end

    always_comb begin
        rd_word = 16'h0000;                     // Unknown address
        if (crtc_hit)
            rd_word = {crtc_data, crtc_index};
        else if (mode_hit)
            rd_word = {2'b00, color_reg, mode_reg};
        rd_word = rd_word & {{8{bytesel[1]}}, {8{bytesel[0]}}};
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ack        <= 1'b0;
            rdata      <= 16'h0000;
            crtc_index <= 8'h00;
            start_hi   <= 8'h00;
            start_lo   <= 8'h00;
            mode_reg   <= 8'h00;                // Video off
            color_reg  <= 6'h00;
        end else begin
            ack   <= new_access;                // Exactly one cycle later
            rdata <= (new_access && !we) ? rd_word : 16'h0000;
            if (new_access && we && crtc_hit) begin
                if (bytesel[0])
                    crtc_index <= wdata[7:0];
                if (bytesel[1]) begin
                    case (crtc_index)
                        CRTC_START_HI: start_hi <= wdata[15:8];
                        CRTC_START_LO: start_lo <= wdata[15:8];
                        default: ;              // Other indices dropped
                    endcase
                end
            end
            if (new_access && we && mode_hit) begin
                if (bytesel[0])
                    mode_reg <= wdata[7:0];
                if (bytesel[1])
                    color_reg <= wdata[13:8];
            end
        end
    end

    assign cfg.start_addr = {start_hi, start_lo};
    assign cfg.video_en   = mode_reg[3];
    assign cfg.bg_color   = color_reg[3:0];
    assign cfg.intensity  = color_reg[4];
    assign cfg.pal_sel    = color_reg[5];

endmodule

`default_nettype wire

// File: rtl/vram.sv
// Byte RAM of 2^AW entries, no reset, read data one cycle after enable; port b is read only
`default_nettype none

module vram #(
    parameter int AW = 14
) (
    input  logic                clock,
    input  cga_pkg::vram_port_t a_port,
    output logic [7:0]          a_rdata,
    input  cga_pkg::vram_port_t b_port,
    output logic [7:0]          b_rdata
);

    logic [7:0] mem [0:2**AW-1];                // Linear frame buffer

    // Host port, old data returned on a write
    always_ff @(posedge clock) begin
        if (a_port.en) begin
            if (a_port.we)
                mem[a_port.addr[AW-1:0]] <= a_port.data;
            a_rdata <= mem[a_port.addr[AW-1:0]];
        end
    end

    // Video port
    always_ff @(posedge clock) begin
        if (b_port.en)
            b_rdata <= mem[b_port.addr[AW-1:0]];   // Scanner fetch
    end

    // Scanner side never stores
    assert property (@(posedge clock) b_port.en |-> !b_port.we)
        else $error("vram: write request on video port");

endmodule

`default_nettype wire

// File: rtl/bus_converter.sv
// Host holds memaccess and req until ack; bytesel 00 completes without touching the RAM
`default_nettype none

module bus_converter #(
    parameter int AW = 14
) (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                memaccess,
    input  cga_pkg::mem_req_t   req,
    output logic [15:0]         rdata,
    output logic                ack,
    output cga_pkg::vram_port_t ram_req,
    input  logic [7:0]          ram_rdata
);

    typedef enum logic [2:0] {
        S_IDLE,                                 // Waiting for memaccess
        S_ONE,                                  // Single byte in flight
        S_LO,                                   // Low byte in flight, high byte next
        S_HI,                                   // High byte in flight
        S_ACK                                   // Last byte returning
    } state_t;

    state_t        state;
    logic          req_en;
    logic          req_we;
    logic [15:0]   req_addr;
    logic [7:0]    req_data;
    logic [7:0]    lo_q;                        // Low byte of a two-byte read
    logic [AW-1:0] lo_addr;
    logic [AW-1:0] hi_addr;
    logic [15:0]   word;

    // Byte addresses wrap at 2^AW
    assign lo_addr = AW'({req.addr, 1'b0});
    assign hi_addr = AW'({req.addr, 1'b1});

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state  <= S_IDLE;
            req_en <= 1'b0;
            req_we <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (memaccess) begin
                        req_en <= |req.bytesel;
                        req_we <= req.we;
                        state  <= (&req.bytesel) ? S_LO : S_ONE;
                    end
                end
                S_LO: state <= S_HI;            // High byte goes out now
                S_ONE, S_HI: begin
                    req_en <= 1'b0;
                    req_we <= 1'b0;
                    state  <= S_ACK;
                end
                default: state <= S_IDLE;       // Back to idle after ack
            endcase
        end
    end

    // Byte address and write data
    always_ff @(posedge clock) begin
        if (state == S_IDLE) begin
            req_addr <= 16'(req.bytesel[0] ? lo_addr : hi_addr);
            req_data <= req.bytesel[0] ? req.wdata[7:0] : req.wdata[15:8];
        end else if (state == S_LO) begin
            req_addr <= 16'(hi_addr);
            req_data <= req.wdata[15:8];
        end
        if (state == S_HI)
            lo_q <= ram_rdata;                  // Low byte returns here
    end

    assign ram_req = '{en: req_en, we: req_we, addr: req_addr, data: req_data};

    // Unselected bytes read zero
    always_comb begin
        case (req.bytesel)
            2'b01:   word = {8'h00, ram_rdata};
            2'b10:   word = {ram_rdata, 8'h00};
            2'b11:   word = {ram_rdata, lo_q};
            default: word = 16'h0000;
        endcase
    end

    assign ack   = (state == S_ACK);
    assign rdata = (ack && memaccess && !req.we) ? word : 16'h0000;

    // One ack per request, idle cycle always follows
    assert property (@(posedge clock) disable iff (!rst_n) ack |=> !ack)
        else $error("bus_converter: ack high on two consecutive cycles");

endmodule

`default_nettype wire

// File: rtl/cga_pkg.sv
// Field widths assume AW of at most 16 bits and a 14-bit host word address
`default_nettype none

package cga_pkg;

    localparam int MAX_AW = 16;                 // Widest RAM byte address allowed

    // Host memory request, held by the host until ack
    typedef struct packed {
        logic [13:0] addr;                      // Word address
        logic [15:0] wdata;
        logic [1:0]  bytesel;                   // Bit 0 low byte, bit 1 high byte
        logic        we;
    } mem_req_t;

    // One byte access on a RAM port
    typedef struct packed {
        logic              en;
        logic              we;
        logic [MAX_AW-1:0] addr;                // Users take the low AW bits
        logic [7:0]        data;
    } vram_port_t;

    // Display configuration from the register block
    typedef struct packed {
        logic [15:0] start_addr;                // CRTC regs 0C/0D
        logic        video_en;                  // Mode bit 3
        logic [3:0]  bg_color;
        logic        pal_sel;
        logic        intensity;
    } crtc_cfg_t;

    // One output pixel, all fields active high
    typedef struct packed {
        logic       hsync;
        logic       vsync;
        logic       hblank;
        logic       vblank;
        logic       de;
        logic [3:0] color;                      // Colour index, no DAC
    } video_t;

    // I/O word addresses, port number shifted right by one
    localparam logic [19:1] CRTC_WORD_ADDR = 19'h001EA;  // 3D4 index, 3D5 data
    localparam logic [19:1] MODE_WORD_ADDR = 19'h001EC;  // 3D8 mode, 3D9 colour select

    // CRTC indices for the display start address
    localparam logic [7:0] CRTC_START_HI = 8'h0C;
    localparam logic [7:0] CRTC_START_LO = 8'h0D;

    // Palettes indexed by pixel value 1 to 3
    typedef logic [3:1][3:0] palette_t;
    localparam palette_t PALETTE0 = {4'd6, 4'd4, 4'd2};  // Green, red, brown
    localparam palette_t PALETTE1 = {4'd7, 4'd5, 4'd3};  // Cyan, magenta, grey

endpackage

`default_nettype wire
